/* test/readCases.txt */
// Columns: group, master, ID, start address, ARLEN (beats minus one), all hex
// Cases of one group start together; group ff ends the list
0 0 3 00000000 3
1 1 5 00010010 0
2 0 a 00020100 7
3 0 2 00050000 2
4 0 1 00010000 4
4 1 7 00020040 2
5 1 9 00030000 3
6 1 f 00020800 5
6 0 0 00001000 5
7 0 4 fffffff0 0
8 1 6 00000040 f
9 0 e 00018000 2
9 1 b 00000ff0 6
ff 0 0 00000000 0

/* compile.f */
src/axiReadPkg.sv
src/readArbiter.sv
src/readAddrRouter.sv
src/readDataRouter.sv
src/defaultReadSlave.sv
src/axiReadInterconnect.sv
test/readSlaveModel.sv
test/tbAxiRead.sv

/* Makefile */
# Verilator build and run of the AXI read interconnect testbench

VERILATOR ?= verilator
TOP ?= tbAxiRead
FILELIST ?= compile.f
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F -x '$(PASS_TEXT)' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tbAxiRead.sv */
`default_nettype none

module tbAxiRead
	import axiReadPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CASE_FIELDS = 5;
	localparam int MAX_CASES = 32;
	localparam int CYCLES_PER_CASE = 40;

	logic ACLK;
	logic rstN;

	// Master side with one slot per master
	logic arValidM [NUM_MASTERS];
	masterIdT arIdM [NUM_MASTERS];
	addrT arAddrM [NUM_MASTERS];
	lenT arLenM [NUM_MASTERS];
	logic rReadyM [NUM_MASTERS];
	wire logic arReadyM [NUM_MASTERS];
	wire masterIdT rIdM [NUM_MASTERS];
	wire dataT rDataM [NUM_MASTERS];
	wire respT rRespM [NUM_MASTERS];
	wire logic rLastM [NUM_MASTERS];
	wire logic rValidM [NUM_MASTERS];

	// Slave side
	wire slaveIdT arIdS [NUM_SLAVES];
	wire addrT arAddrS [NUM_SLAVES];
	wire lenT arLenS [NUM_SLAVES];
	wire logic arValidS [NUM_SLAVES];
	wire logic arReadyS [NUM_SLAVES];
	wire slaveIdT rIdS [NUM_SLAVES];
	wire dataT rDataS [NUM_SLAVES];
	wire respT rRespS [NUM_SLAVES];
	wire logic rLastS [NUM_SLAVES];
	wire logic rValidS [NUM_SLAVES];
	wire logic rReadyS [NUM_SLAVES];

	logic [31:0] caseMem [MAX_CASES * CASE_FIELDS];
	int numCases;
	int doneCount;
	logic inData [NUM_MASTERS];
	int doneOrder [$];

	axiReadInterconnect i_dut (
		.ACLK(ACLK), .rstN(rstN),
		.ARID_M0(arIdM[0]), .ARADDR_M0(arAddrM[0]), .ARLEN_M0(arLenM[0]),
		.ARVALID_M0(arValidM[0]), .ARREADY_M0(arReadyM[0]), .RID_M0(rIdM[0]),
		.RDATA_M0(rDataM[0]), .RRESP_M0(rRespM[0]), .RLAST_M0(rLastM[0]),
		.RVALID_M0(rValidM[0]), .RREADY_M0(rReadyM[0]),
		.ARID_M1(arIdM[1]), .ARADDR_M1(arAddrM[1]), .ARLEN_M1(arLenM[1]),
		.ARVALID_M1(arValidM[1]), .ARREADY_M1(arReadyM[1]), .RID_M1(rIdM[1]),
		.RDATA_M1(rDataM[1]), .RRESP_M1(rRespM[1]), .RLAST_M1(rLastM[1]),
		.RVALID_M1(rValidM[1]), .RREADY_M1(rReadyM[1]),
		.ARID_S0(arIdS[0]), .ARADDR_S0(arAddrS[0]), .ARLEN_S0(arLenS[0]),
		.ARVALID_S0(arValidS[0]), .ARREADY_S0(arReadyS[0]), .RID_S0(rIdS[0]),
		.RDATA_S0(rDataS[0]), .RRESP_S0(rRespS[0]), .RLAST_S0(rLastS[0]),
		.RVALID_S0(rValidS[0]), .RREADY_S0(rReadyS[0]),
		.ARID_S1(arIdS[1]), .ARADDR_S1(arAddrS[1]), .ARLEN_S1(arLenS[1]),
		.ARVALID_S1(arValidS[1]), .ARREADY_S1(arReadyS[1]), .RID_S1(rIdS[1]),
		.RDATA_S1(rDataS[1]), .RRESP_S1(rRespS[1]), .RLAST_S1(rLastS[1]),
		.RVALID_S1(rValidS[1]), .RREADY_S1(rReadyS[1]),
		.ARID_S2(arIdS[2]), .ARADDR_S2(arAddrS[2]), .ARLEN_S2(arLenS[2]),
		.ARVALID_S2(arValidS[2]), .ARREADY_S2(arReadyS[2]), .RID_S2(rIdS[2]),
		.RDATA_S2(rDataS[2]), .RRESP_S2(rRespS[2]), .RLAST_S2(rLastS[2]),
		.RVALID_S2(rValidS[2]), .RREADY_S2(rReadyS[2])
	);

	// One memory model per mapped region
	for (genvar s = 0; s < NUM_SLAVES; s++) begin : gSlave
		readSlaveModel #(.SLAVE_INDEX(s)) i_slave (
			.ACLK(ACLK), .rstN(rstN),
			.ARID(arIdS[s]), .ARADDR(arAddrS[s]), .ARLEN(arLenS[s]),
			.ARVALID(arValidS[s]), .ARREADY(arReadyS[s]),
			.RID(rIdS[s]), .RDATA(rDataS[s]), .RRESP(rRespS[s]),
			.RLAST(rLastS[s]), .RVALID(rValidS[s]), .RREADY(rReadyS[s])
		);
	end

	initial ACLK = 1'b0;
	always #2 ACLK = ~ACLK;

	// ------------------------------------------------------------------------
	// Expected values and compare tasks
	// ------------------------------------------------------------------------
	function automatic dataT expectedData(addrT addr, int beat);
		logic [15:0] region;
		region = addr[31:16];
		if (region < NUM_SLAVES) begin
			return (addr + addrT'(4 * beat)) ^ (dataT'(region) << 24);
		end
		return '0;
	endfunction

	function automatic respT expectedResp(addrT addr);
		return (addr[31:16] < NUM_SLAVES) ? OKAY : DECERR;
	endfunction

	task automatic stopRun(string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic checkData(string name, dataT got, dataT exp);
		if (got !== exp) begin
			stopRun($sformatf("Error at %0d ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic checkResp(string name, respT got, respT exp);
		if (got !== exp) begin
			stopRun($sformatf("Error at %0d ns: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
		end
	endtask

	task automatic checkId(string name, masterIdT got, masterIdT exp);
		if (got !== exp) begin
			stopRun($sformatf("Error at %0d ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic checkSlaveId(string name, slaveIdT got, slaveIdT exp);
		if (got !== exp) begin
			stopRun($sformatf("Error at %0d ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			stopRun($sformatf("Error at %0d ns: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	// Quiet buses before any request
	task automatic checkIdleBus();
		repeat (4) begin
			@(negedge ACLK);
			for (int s = 0; s < NUM_SLAVES; s++) begin
				checkFlag($sformatf("ARVALID_S%0d", s), arValidS[s], 1'b0);
				checkFlag($sformatf("RREADY_S%0d", s), rReadyS[s], 1'b0);
			end
			for (int m = 0; m < NUM_MASTERS; m++) begin
				checkFlag($sformatf("RVALID_M%0d", m), rValidM[m], 1'b0);
				checkFlag($sformatf("ARREADY_M%0d", m), arReadyM[m], 1'b0);
			end
		end
	endtask

	// Master driver entered 1 ns after a rising edge
	task automatic runRead(int m, masterIdT id, addrT addr, lenT len);
		int beat;
		int region;
		string tag;
		tag = $sformatf("_M%0d beat ", m);
		region = int'(addr[31:16]);
		arIdM[m] = id;
		arAddrM[m] = addr;
		arLenM[m] = len;
		arValidM[m] = 1'b1;
		do begin
			@(negedge ACLK);
		end while (!arReadyM[m]);
		// Request reaches only the addressed slave with the widened ID
		for (int s = 0; s < NUM_SLAVES; s++) begin
			checkFlag($sformatf("ARVALID_S%0d", s), arValidS[s], region == s);
		end
		if (region < NUM_SLAVES) begin
			checkSlaveId($sformatf("ARID_S%0d", region), arIdS[region],
				{masterIdT'(m), id});
		end
		@(posedge ACLK);
		inData[m] = 1'b1;
		#1;
		arValidM[m] = 1'b0;
		beat = 0;
		while (beat <= int'(len)) begin
			rReadyM[m] = ($urandom_range(3) != 0);
			@(negedge ACLK);
			if (rValidM[m] && rReadyM[m]) begin
				checkId({"RID", tag, $sformatf("%0d", beat)}, rIdM[m], id);
				checkData({"RDATA", tag, $sformatf("%0d", beat)}, rDataM[m],
					expectedData(addr, beat));
				checkResp({"RRESP", tag, $sformatf("%0d", beat)}, rRespM[m],
					expectedResp(addr));
				checkFlag({"RLAST", tag, $sformatf("%0d", beat)}, rLastM[m],
					beat == int'(len));
				beat++;
			end
			@(posedge ACLK);
			if (beat > int'(len)) begin
				inData[m] = 1'b0;
			end
			#1;
		end
		rReadyM[m] = 1'b0;
		doneOrder.push_back(m);
	endtask

	// Only the master in its data phase may see RVALID
	always @(negedge ACLK) begin
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (rstN && rValidM[m] && !inData[m]) begin
				stopRun($sformatf("RVALID_M%0d rose while that master had no read in flight", m));
			end
		end
	end

	initial begin
		@(posedge rstN);
		repeat (numCases * CYCLES_PER_CASE) @(posedge ACLK);
		stopRun($sformatf("Watchdog expired after %0d cycles with reads still pending",
			numCases * CYCLES_PER_CASE));
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int idx;
		int group;
		int m;
		int expPtr;
		logic has [NUM_MASTERS];
		masterIdT caseId [NUM_MASTERS];
		addrT caseAddr [NUM_MASTERS];
		lenT caseLen [NUM_MASTERS];
		void'($urandom(35123));
		rstN = 1'b0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			arValidM[i] = 1'b0;
			arIdM[i] = '0;
			arAddrM[i] = '0;
			arLenM[i] = '0;
			rReadyM[i] = 1'b0;
			inData[i] = 1'b0;
		end
		doneCount = 0;
		$readmemh("test/readCases.txt", caseMem);
		numCases = 0;
		while (numCases < MAX_CASES && caseMem[numCases * CASE_FIELDS] != 32'hff) begin
			numCases++;
		end
		repeat (3) @(posedge ACLK);
		#1;
		rstN = 1'b1;
		checkIdleBus();

		expPtr = 0;
		idx = 0;
		while (idx < numCases) begin
			group = int'(caseMem[idx * CASE_FIELDS]);
			has[0] = 1'b0;
			has[1] = 1'b0;
			while (idx < numCases && int'(caseMem[idx * CASE_FIELDS]) == group) begin
				m = int'(caseMem[idx * CASE_FIELDS + 1]);
				has[m] = 1'b1;
				caseId[m] = masterIdT'(caseMem[idx * CASE_FIELDS + 2]);
				caseAddr[m] = caseMem[idx * CASE_FIELDS + 3];
				caseLen[m] = lenT'(caseMem[idx * CASE_FIELDS + 4]);
				idx++;
			end
			doneOrder.delete();
			@(posedge ACLK);
			#1;
			fork
				begin
					if (has[0]) runRead(0, caseId[0], caseAddr[0], caseLen[0]);
				end
				begin
					if (has[1]) runRead(1, caseId[1], caseAddr[1], caseLen[1]);
				end
			join
			if (has[0] && has[1] && doneOrder[0] != expPtr) begin
				stopRun($sformatf("Error at %0d ns: first master to finish is M%0d, expected M%0d",
					$time, doneOrder[0], expPtr));
			end
			// Pointer favors the master not granted last
			foreach (doneOrder[i]) begin
				expPtr = 1 - doneOrder[i];
			end
			doneCount += doneOrder.size();
		end

		repeat (4) @(posedge ACLK);
		if (doneCount == numCases) begin
			$display("** PASS **");
			$finish;
		end else begin
			stopRun($sformatf("Only %0d of %0d read cases completed", doneCount, numCases));
		end
	end

endmodule

`default_nettype wire

/* test/readSlaveModel.sv */
`default_nettype none

module readSlaveModel
	import axiReadPkg::*;
#(
	parameter int SLAVE_INDEX = 0
) (
	input logic ACLK,
	input logic rstN,
	input slaveIdT ARID,
	input addrT ARADDR,
	input lenT ARLEN,
	input logic ARVALID,
	output logic ARREADY,
	output slaveIdT RID,
	output dataT RDATA,
	output respT RRESP,
	output logic RLAST,
	output logic RVALID,
	input logic RREADY
);

	timeunit 1ns;
	timeprecision 100ps;

	slaveIdT reqId;
	addrT reqAddr;
	lenT reqLen;
	int beat;
	logic busy;
	logic arFire;
	logic rFire;

	// Handshakes sampled at the falling edge, outputs move 1 ns after the rising edge
	initial begin
		ARREADY = 1'b0;
		RVALID = 1'b0;
		RLAST = 1'b0;
		RID = '0;
		RDATA = '0;
		RRESP = OKAY;
		busy = 1'b0;
		beat = 0;
		forever begin
			@(negedge ACLK);
			arFire = ARVALID && ARREADY;
			rFire = RVALID && RREADY;
			@(posedge ACLK);
			#1;
			if (!rstN) begin
				ARREADY = 1'b0;
				RVALID = 1'b0;
				RLAST = 1'b0;
				busy = 1'b0;
			end else begin
				if (arFire) begin
					reqId = ARID;
					reqAddr = ARADDR;
					reqLen = ARLEN;
					busy = 1'b1;
					beat = 0;
				end else if (rFire) begin
					RVALID = 1'b0;
					if (RLAST) begin
						busy = 1'b0;
					end else begin
						beat++;
					end
				end
				// Random idle cycles before a beat
				if (busy && !RVALID && $urandom_range(2) != 0) begin
					RVALID = 1'b1;
					RID = reqId;
					RDATA = (reqAddr + addrT'(4 * beat)) ^ (dataT'(SLAVE_INDEX) << 24);
					RRESP = OKAY;
					RLAST = (beat == int'(reqLen));
				end
				ARREADY = !busy;
			end
		end
	end

endmodule

`default_nettype wire

/* src/axiReadInterconnect.sv */
`default_nettype none

module axiReadInterconnect
	import axiReadPkg::*;
(
	input logic ACLK,
	input logic rstN,

	// ------------------------------------------------------------------------
	// Master side
	// ------------------------------------------------------------------------
	input masterIdT ARID_M0,
	input addrT ARADDR_M0,
	input lenT ARLEN_M0,
	input logic ARVALID_M0,
	output logic ARREADY_M0,
	output masterIdT RID_M0,
	output dataT RDATA_M0,
	output respT RRESP_M0,
	output logic RLAST_M0,
	output logic RVALID_M0,
	input logic RREADY_M0,

	input masterIdT ARID_M1,
	input addrT ARADDR_M1,
	input lenT ARLEN_M1,
	input logic ARVALID_M1,
	output logic ARREADY_M1,
	output masterIdT RID_M1,
	output dataT RDATA_M1,
	output respT RRESP_M1,
	output logic RLAST_M1,
	output logic RVALID_M1,
	input logic RREADY_M1,

	// ------------------------------------------------------------------------
	// Slave side
	// ------------------------------------------------------------------------
	output slaveIdT ARID_S0,
	output addrT ARADDR_S0,
	output lenT ARLEN_S0,
	output logic ARVALID_S0,
	input logic ARREADY_S0,
	input slaveIdT RID_S0,
	input dataT RDATA_S0,
	input respT RRESP_S0,
	input logic RLAST_S0,
	input logic RVALID_S0,
	output logic RREADY_S0,

	output slaveIdT ARID_S1,
	output addrT ARADDR_S1,
	output lenT ARLEN_S1,
	output logic ARVALID_S1,
	input logic ARREADY_S1,
	input slaveIdT RID_S1,
	input dataT RDATA_S1,
	input respT RRESP_S1,
	input logic RLAST_S1,
	input logic RVALID_S1,
	output logic RREADY_S1,

	output slaveIdT ARID_S2,
	output addrT ARADDR_S2,
	output lenT ARLEN_S2,
	output logic ARVALID_S2,
	input logic ARREADY_S2,
	input slaveIdT RID_S2,
	input dataT RDATA_S2,
	input respT RRESP_S2,
	input logic RLAST_S2,
	input logic RVALID_S2,
	output logic RREADY_S2
);

	logic [NUM_MASTERS-1:0] grant;
	readStateT state;
	logic arHandShake;
	logic rHandShake;
	slaveSelT sel;

	// Shared AR bus
	slaveIdT arId;
	addrT arAddr;
	lenT arLen;

	// Shared R payload
	masterIdT rId;
	dataT rData;
	respT rResp;
	logic rLast;

	// Default slave channels
	logic dsArValid;
	slaveIdT dsRid;
	dataT dsRdata;
	respT dsRresp;
	logic dsRlast;
	logic dsRvalid;
	logic dsRready;

	readArbiter i_readArbiter (
		.ACLK(ACLK),
		.rstN(rstN),
		.arValid({ARVALID_M1, ARVALID_M0}),
		.rHandShake(rHandShake),
		.rLast(rLast),
		.arHandShake(arHandShake),
		.grant(grant),
		.state(state)
	);

	readAddrRouter i_readAddrRouter (
		.ACLK(ACLK),
		.rstN(rstN),
		.grant(grant),
		.state(state),
		.ARID_M({ARID_M1, ARID_M0}),
		.ARADDR_M({ARADDR_M1, ARADDR_M0}),
		.ARLEN_M({ARLEN_M1, ARLEN_M0}),
		.ARVALID_M({ARVALID_M1, ARVALID_M0}),
		.ARREADY_M({ARREADY_M1, ARREADY_M0}),
		.arId(arId),
		.arAddr(arAddr),
		.arLen(arLen),
		.arValidS({ARVALID_S2, ARVALID_S1, ARVALID_S0}),
		.arReadyS({ARREADY_S2, ARREADY_S1, ARREADY_S0}),
		.dsArValid(dsArValid),
		// Default slave takes every request at once
		.dsArReady(1'b1),
		.arHandShake(arHandShake),
		.sel(sel)
	);

	defaultReadSlave i_defaultReadSlave (
		.ACLK(ACLK),
		.rstN(rstN),
		.arValid(dsArValid),
		.arId(arId),
		.arLen(arLen),
		.rReady(dsRready),
		.rId(dsRid),
		.rData(dsRdata),
		.rResp(dsRresp),
		.rLast(dsRlast),
		.rValid(dsRvalid)
	);

	readDataRouter i_readDataRouter (
		.sel(sel),
		.RID_S({RID_S2, RID_S1, RID_S0}),
		.RDATA_S({RDATA_S2, RDATA_S1, RDATA_S0}),
		.RRESP_S({RRESP_S2, RRESP_S1, RRESP_S0}),
		.RLAST_S({RLAST_S2, RLAST_S1, RLAST_S0}),
		.RVALID_S({RVALID_S2, RVALID_S1, RVALID_S0}),
		.dsRid(dsRid),
		.dsRdata(dsRdata),
		.dsRresp(dsRresp),
		.dsRlast(dsRlast),
		.dsRvalid(dsRvalid),
		.RREADY_S({RREADY_S2, RREADY_S1, RREADY_S0}),
		.dsRready(dsRready),
		.rId(rId),
		.rData(rData),
		.rResp(rResp),
		.rLast(rLast),
		.RVALID_M({RVALID_M1, RVALID_M0}),
		.RREADY_M({RREADY_M1, RREADY_M0}),
		.rHandShake(rHandShake)
	);

	// AR broadcast, only ARVALID is per slave
	assign ARID_S0 = arId;
	assign ARADDR_S0 = arAddr;
	assign ARLEN_S0 = arLen;
	assign ARID_S1 = arId;
	assign ARADDR_S1 = arAddr;
	assign ARLEN_S1 = arLen;
	assign ARID_S2 = arId;
	assign ARADDR_S2 = arAddr;
	assign ARLEN_S2 = arLen;

	// R broadcast, only RVALID is per master
	assign RID_M0 = rId;
	assign RDATA_M0 = rData;
	assign RRESP_M0 = rResp;
	assign RLAST_M0 = rLast;
	assign RID_M1 = rId;
	assign RDATA_M1 = rData;
	assign RRESP_M1 = rResp;
	assign RLAST_M1 = rLast;

endmodule

`default_nettype wire

/* src/defaultReadSlave.sv */
`default_nettype none

module defaultReadSlave
	import axiReadPkg::*;
(
	input logic ACLK,
	input logic rstN,
	input logic arValid,
	input slaveIdT arId,
	input lenT arLen,
	input logic rReady,
	output slaveIdT rId,
	output dataT rData,
	output respT rResp,
	output logic rLast,
	output logic rValid
);

	// Beats still to follow the current one
	lenT beatsLeft;

	// Every unmapped read is a decode error with zero data
	assign rData = '0;
	assign rResp = DECERR;

	always_ff @(posedge ACLK or negedge rstN) begin
		if (!rstN) begin
			rValid <= 1'b0;
			rLast <= 1'b0;
			beatsLeft <= '0;
		end else if (arValid) begin
			rValid <= 1'b1;
			rLast <= (arLen == '0);
			beatsLeft <= arLen;
		end else if (rValid && rReady) begin
			if (rLast) begin
				rValid <= 1'b0;
				rLast <= 1'b0;
			end else begin
				beatsLeft <= beatsLeft - 1'b1;
				rLast <= (beatsLeft == lenT'(1));
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (arValid) begin
			rId <= arId;
		end
	end

endmodule

`default_nettype wire

/* src/readDataRouter.sv */
`default_nettype none

module readDataRouter
	import axiReadPkg::*;
(
	input slaveSelT sel,
	input slaveIdT [NUM_SLAVES-1:0] RID_S,
	input dataT [NUM_SLAVES-1:0] RDATA_S,
	input logic [NUM_SLAVES-1:0][1:0] RRESP_S,
	input logic [NUM_SLAVES-1:0] RLAST_S,
	input logic [NUM_SLAVES-1:0] RVALID_S,
	input slaveIdT dsRid,
	input dataT dsRdata,
	input respT dsRresp,
	input logic dsRlast,
	input logic dsRvalid,
	output logic [NUM_SLAVES-1:0] RREADY_S,
	output logic dsRready,
	output masterIdT rId,
	output dataT rData,
	output respT rResp,
	output logic rLast,
	output logic [NUM_MASTERS-1:0] RVALID_M,
	input logic [NUM_MASTERS-1:0] RREADY_M,
	output logic rHandShake
);

	slaveIdT wideId;
	logic [SID_BITS-MID_BITS-1:0] owner;
	logic beatValid;
	logic beatReady;

	// Beat from the slave captured at the AR handshake
	always_comb begin
		wideId = dsRid;
		rData = dsRdata;
		rResp = dsRresp;
		rLast = dsRlast;
		beatValid = dsRvalid;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (sel == slaveSelT'(s)) begin
				wideId = RID_S[s];
				rData = RDATA_S[s];
				rResp = respT'(RRESP_S[s]);
				rLast = RLAST_S[s];
				beatValid = RVALID_S[s];
			end
		end
	end

	// Upper ID bits name the owning master
	assign owner = wideId[SID_BITS-1:MID_BITS];
	assign rId = wideId[MID_BITS-1:0];

	always_comb begin
		beatReady = 1'b0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			RVALID_M[m] = beatValid && (owner == m);
			if (owner == m) begin
				beatReady = RREADY_M[m];
			end
		end
	end

	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			RREADY_S[s] = beatValid && beatReady && (sel == slaveSelT'(s));
		end
	end

	assign dsRready = beatValid && beatReady && (sel == SEL_DEFAULT);
	assign rHandShake = beatValid && beatReady;

endmodule

`default_nettype wire

/* src/readAddrRouter.sv */
`default_nettype none

module readAddrRouter
	import axiReadPkg::*;
(
	input logic ACLK,
	input logic rstN,
	input logic [NUM_MASTERS-1:0] grant,
	input readStateT state,
	input masterIdT [NUM_MASTERS-1:0] ARID_M,
	input addrT [NUM_MASTERS-1:0] ARADDR_M,
	input lenT [NUM_MASTERS-1:0] ARLEN_M,
	input logic [NUM_MASTERS-1:0] ARVALID_M,
	output logic [NUM_MASTERS-1:0] ARREADY_M,
	output slaveIdT arId,
	output addrT arAddr,
	output lenT arLen,
	output logic [NUM_SLAVES-1:0] arValidS,
	input logic [NUM_SLAVES-1:0] arReadyS,
	output logic dsArValid,
	input logic dsArReady,
	output logic arHandShake,
	output slaveSelT sel
);

	logic [SID_BITS-MID_BITS-1:0] mIdx;
	masterIdT mId;
	logic reqValid;
	logic [ADDR_BITS-REGION_SHIFT-1:0] region;
	slaveSelT decSel;
	logic slvReady;

	// Granted master's request
	always_comb begin
		mIdx = '0;
		mId = '0;
		arAddr = '0;
		arLen = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (grant[m]) begin
				mIdx = (SID_BITS-MID_BITS)'(m);
				mId = ARID_M[m];
				arAddr = ARADDR_M[m];
				arLen = ARLEN_M[m];
			end
		end
	end

	assign arId = {mIdx, mId};
	assign reqValid = (state == RD_ADDR) && |(grant & ARVALID_M);

	// ------------------------------------------------------------------------
	// Region decode
	// ------------------------------------------------------------------------
	assign region = arAddr[ADDR_BITS-1:REGION_SHIFT];

	always_comb begin
		case (region)
			REGION_S0: decSel = SEL_S0;
			REGION_S1: decSel = SEL_S1;
			REGION_S2: decSel = SEL_S2;
			default: decSel = SEL_DEFAULT;
		endcase
	end

	always_comb begin
		slvReady = dsArReady && (decSel == SEL_DEFAULT);
		for (int s = 0; s < NUM_SLAVES; s++) begin
			arValidS[s] = reqValid && (decSel == slaveSelT'(s));
			if (decSel == slaveSelT'(s)) begin
				slvReady = arReadyS[s];
			end
		end
	end

	assign dsArValid = reqValid && (decSel == SEL_DEFAULT);
	assign arHandShake = reqValid && slvReady;
	assign ARREADY_M = (state == RD_ADDR && slvReady) ? grant : '0;

	// R path follows this until the next AR handshake
	always_ff @(posedge ACLK or negedge rstN) begin
		if (!rstN) begin
			sel <= SEL_DEFAULT;
		end else if (arHandShake) begin
			sel <= decSel;
		end
	end

endmodule

`default_nettype wire

/* src/readArbiter.sv */
`default_nettype none

module readArbiter
	import axiReadPkg::*;
(
	input logic ACLK,
	input logic rstN,
	input logic [NUM_MASTERS-1:0] arValid,
	input logic rHandShake,
	input logic rLast,
	input logic arHandShake,
	output logic [NUM_MASTERS-1:0] grant,
	output readStateT state
);

	// Master index, same width as the upper ID field
	logic [SID_BITS-MID_BITS-1:0] ptr;
	logic [SID_BITS-MID_BITS-1:0] pick;
	logic found;

	// Round robin search: from ptr upward first, then wrap to M0
	always_comb begin
		pick = ptr;
		found = 1'b0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			if (!found && i >= int'(ptr) && arValid[i]) begin
				pick = (SID_BITS-MID_BITS)'(i);
				found = 1'b1;
			end
		end
		for (int i = 0; i < NUM_MASTERS; i++) begin
			if (!found && arValid[i]) begin
				pick = (SID_BITS-MID_BITS)'(i);
				found = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Transaction FSM, grant frozen from selection to the last R beat
	// ------------------------------------------------------------------------
	always_ff @(posedge ACLK or negedge rstN) begin
		if (!rstN) begin
			state <= RD_IDLE;
			grant <= '0;
			ptr <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (found) begin
						state <= RD_ADDR;
						for (int m = 0; m < NUM_MASTERS; m++) begin
							grant[m] <= (int'(pick) == m);
						end
						// Favor the next master on the following round
						if (int'(pick) == NUM_MASTERS - 1) begin
							ptr <= '0;
						end else begin
							ptr <= pick + 1'b1;
						end
					end
				end
				RD_ADDR: begin
					if (arHandShake) begin
						state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (rHandShake && rLast) begin
						state <= RD_IDLE;
						grant <= '0;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/axiReadPkg.sv */
`default_nettype none

package axiReadPkg;

	// Bus widths
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32;
	localparam int LEN_BITS = 4;
	localparam int MID_BITS = 4;
	localparam int SID_BITS = 8;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 3;

	// ------------------------------------------------------------------------
	// Address map, region field is everything above REGION_SHIFT
	// ------------------------------------------------------------------------
	localparam int REGION_SHIFT = 16;
	localparam logic [ADDR_BITS-REGION_SHIFT-1:0] REGION_S0 = 16'd0;
	localparam logic [ADDR_BITS-REGION_SHIFT-1:0] REGION_S1 = 16'd1;
	localparam logic [ADDR_BITS-REGION_SHIFT-1:0] REGION_S2 = 16'd2;

	typedef logic [ADDR_BITS-1:0] addrT;
	typedef logic [DATA_BITS-1:0] dataT;
	// Beats minus one
	typedef logic [LEN_BITS-1:0] lenT;
	typedef logic [MID_BITS-1:0] masterIdT;
	// Master index on top, master ID below
	typedef logic [SID_BITS-1:0] slaveIdT;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} respT;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} readStateT;

	typedef enum logic [1:0] {
		SEL_S0,
		SEL_S1,
		SEL_S2,
		SEL_DEFAULT
	} slaveSelT;

endpackage

`default_nettype wire
